// File: hdl/indirect_fifo.sv
// Indirect data FIFO
`default_nettype none

module indirect_fifo (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  soft_clr_i,
  input  logic                                  clr_i,
  input  logic                                  push_i,
  input  logic [recovery_pkg::DataWidth-1:0]    push_data_i,
  input  logic                                  pop_i,
  input  logic                                  image_activated_i,
  output logic [recovery_pkg::DataWidth-1:0]    head_o,
  output logic                                  full_o,
  output logic                                  empty_o,
  output logic [recovery_pkg::FifoIdxWidth-1:0] wr_idx_o,
  output logic [recovery_pkg::FifoIdxWidth-1:0] rd_idx_o,
  output logic                                  payload_available_o
);
  import recovery_pkg::*;

  logic [DataWidth-1:0]    mem_q [IndirectFifoDepth];
  logic [FifoIdxWidth-1:0] wr_q;
  logic [FifoIdxWidth-1:0] rd_q;
  logic [FifoIdxWidth:0]   cnt_q;
  logic                    do_push;
  logic                    do_pop;
  logic                    payload_q;

  assign full_o  = (cnt_q == (FifoIdxWidth + 1)'(IndirectFifoDepth));
  assign empty_o = (cnt_q == '0);
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  always_ff @(posedge clk_i) begin
    if (do_push) mem_q[wr_q] <= push_data_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_q      <= '0;
      rd_q      <= '0;
      cnt_q     <= '0;
      payload_q <= 1'b0;
    end else if (clr_i || soft_clr_i) begin
      wr_q      <= '0;
      rd_q      <= '0;
      cnt_q     <= '0;
      payload_q <= 1'b0;
    end else begin
      if (do_push) begin
        wr_q <= (wr_q == FifoIdxWidth'(IndirectFifoDepth - 1)) ? '0 : wr_q + 1'b1;
      end
      if (do_pop) begin
        rd_q <= (rd_q == FifoIdxWidth'(IndirectFifoDepth - 1)) ? '0 : rd_q + 1'b1;
      end
      cnt_q <= cnt_q + (FifoIdxWidth + 1)'(do_push) - (FifoIdxWidth + 1)'(do_pop);
      // Full buffer, or any data once the image is activated
      if (full_o || (!empty_o && image_activated_i)) payload_q <= 1'b1;
      else if (empty_o) payload_q <= 1'b0;
    end
  end

  assign head_o              = mem_q[rd_q];
  assign wr_idx_o            = wr_q;
  assign rd_idx_o            = rd_q;
  assign payload_available_o = payload_q;

endmodule

`default_nettype wire

// File: hdl/recovery_executor.sv
// Recovery command executor
`default_nettype none

module recovery_executor (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 cmd_valid_i,
  input  logic                                 cmd_is_rd_i,
  input  logic [7:0]                           cmd_code_i,
  input  logic [recovery_pkg::CmdLenWidth-1:0] cmd_len_i,
  input  logic                                 cmd_error_i,
  output logic                                 cmd_done_o,
  output logic                                 rx_rreq_o,
  input  logic                                 rx_rack_i,
  input  logic [recovery_pkg::DataWidth-1:0]   rx_rdata_i,
  output logic                                 res_valid_o,
  input  logic                                 res_ready_i,
  output logic [recovery_pkg::CmdLenWidth-1:0] res_len_o,
  output logic                                 res_dvalid_o,
  input  logic                                 res_dready_i,
  output logic [7:0]                           res_data_o,
  output logic                                 res_dlast_o,
  input  logic                                 fifo_pop_i,
  output logic [recovery_pkg::DataWidth-1:0]   fifo_rdata_o,
  output logic                                 fifo_empty_o,
  input  logic                                 recovery_enable_i,
  input  logic                                 recovery_mode_i,
  output logic                                 rx_queue_clr_o,
  output logic                                 image_activated_o,
  output logic                                 payload_available_o
);
  import recovery_pkg::*;

  logic                    load_words;
  logic                    load_bytes;
  logic                    dec;
  logic                    byte_adv;
  logic                    last;
  logic [1:0]              byte_idx;
  csr_e                    csr_idx;
  logic                    wr_en;
  logic                    status_upd;
  logic                    fifo_push;
  logic                    fifo_full;
  logic                    fifo_clr;
  logic [FifoIdxWidth-1:0] wr_idx;
  logic [FifoIdxWidth-1:0] rd_idx;

  recovery_fsm u_fsm (
    .clk_i,
    .rst_ni,
    .recovery_enable_i,
    .recovery_mode_i,
    .cmd_valid_i,
    .cmd_is_rd_i,
    .cmd_code_i,
    .cmd_len_i,
    .cmd_error_i,
    .rx_rack_i,
    .res_ready_i,
    .res_dready_i,
    .last_i         (last),
    .byte_idx_i     (byte_idx),
    .fifo_full_i    (fifo_full),
    .cmd_done_o,
    .rx_rreq_o,
    .res_valid_o,
    .res_len_o,
    .res_dvalid_o,
    .res_dlast_o,
    .rx_queue_clr_o,
    .load_words_o   (load_words),
    .load_bytes_o   (load_bytes),
    .dec_o          (dec),
    .byte_adv_o     (byte_adv),
    .csr_idx_o      (csr_idx),
    .wr_en_o        (wr_en),
    .status_upd_o   (status_upd),
    .fifo_push_o    (fifo_push)
  );

  // The held length is the word count source on writes, the byte count on reads
  xfer_counter u_counter (
    .clk_i,
    .rst_ni,
    .len_i        (res_len_o),
    .load_words_i (load_words),
    .load_bytes_i (load_bytes),
    .dec_i        (dec),
    .byte_adv_i   (byte_adv),
    .last_o       (last),
    .byte_idx_o   (byte_idx)
  );

  recovery_regs u_regs (
    .clk_i,
    .rst_ni,
    .csr_idx_i         (csr_idx),
    .byte_idx_i        (byte_idx),
    .wr_en_i           (wr_en),
    .wr_data_i         (rx_rdata_i),
    .status_upd_i      (status_upd),
    .cmd_error_i,
    .fifo_full_i       (fifo_full),
    .fifo_empty_i      (fifo_empty_o),
    .wr_idx_i          (wr_idx),
    .rd_idx_i          (rd_idx),
    .rd_byte_o         (res_data_o),
    .fifo_clr_o        (fifo_clr),
    .image_activated_o
  );

  indirect_fifo u_fifo (
    .clk_i,
    .rst_ni,
    .soft_clr_i          (!recovery_enable_i),
    .clr_i               (fifo_clr),
    .push_i              (fifo_push),
    .push_data_i         (rx_rdata_i),
    .pop_i               (fifo_pop_i),
    .image_activated_i   (image_activated_o),
    .head_o              (fifo_rdata_o),
    .full_o              (fifo_full),
    .empty_o             (fifo_empty_o),
    .wr_idx_o            (wr_idx),
    .rd_idx_o            (rd_idx),
    .payload_available_o
  );

endmodule

`default_nettype wire

// File: hdl/recovery_fsm.sv
// Recovery command state machine
`default_nettype none

module recovery_fsm (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 recovery_enable_i,
  input  logic                                 recovery_mode_i,
  input  logic                                 cmd_valid_i,
  input  logic                                 cmd_is_rd_i,
  input  logic [7:0]                           cmd_code_i,
  input  logic [recovery_pkg::CmdLenWidth-1:0] cmd_len_i,
  input  logic                                 cmd_error_i,
  input  logic                                 rx_rack_i,
  input  logic                                 res_ready_i,
  input  logic                                 res_dready_i,
  input  logic                                 last_i,
  input  logic [1:0]                           byte_idx_i,
  input  logic                                 fifo_full_i,
  output logic                                 cmd_done_o,
  output logic                                 rx_rreq_o,
  output logic                                 res_valid_o,
  output logic [recovery_pkg::CmdLenWidth-1:0] res_len_o,
  output logic                                 res_dvalid_o,
  output logic                                 res_dlast_o,
  output logic                                 rx_queue_clr_o,
  output logic                                 load_words_o,
  output logic                                 load_bytes_o,
  output logic                                 dec_o,
  output logic                                 byte_adv_o,
  output recovery_pkg::csr_e                   csr_idx_o,
  output logic                                 wr_en_o,
  output logic                                 status_upd_o,
  output logic                                 fifo_push_o
);
  import recovery_pkg::*;

  typedef enum logic [2:0] {
    Idle, CsrWrite, FifoWrite, CsrRead, CsrReadLen, CsrReadData, Error, Done
  } state_e;

  state_e                 state_q;
  state_e                 state_d;
  state_e                 st;
  csr_e                   start_idx;
  csr_e                   end_idx;
  csr_e                   csr_q;
  csr_e                   end_q;
  logic [CmdLenWidth-1:0] reg_len;
  logic [CmdLenWidth-1:0] len_q;
  logic                   accept;
  logic                   illegal;
  logic                   rd_xfer;
  logic                   req_pend_q;
  logic                   load_q;

  // Seen as idle while recovery is disabled
  assign st      = recovery_enable_i ? state_q : Idle;
  assign accept  = recovery_enable_i && (state_q == Idle) && cmd_valid_i;
  assign illegal = cmd_error_i || (cmd_code_i < CmdLowest) || (cmd_code_i > CmdHighest) ||
                   (!recovery_mode_i && (cmd_code_i > CmdLastCommon));
  assign rd_xfer = (st == CsrReadData) && res_dready_i;

  // Word range and byte length of the addressed register
  always_comb begin
    start_idx = CSR_INVALID;
    end_idx   = CSR_INVALID;
    reg_len   = CmdLenWidth'(4);
    case (cmd_code_i)
      CMD_PROT_CAP: begin
        start_idx = CSR_PROT_CAP_0;
        end_idx   = CSR_PROT_CAP_3;
        reg_len   = LenProtCap;
      end
      CMD_DEVICE_STATUS: begin
        start_idx = CSR_DEVICE_STATUS_0;
        end_idx   = CSR_DEVICE_STATUS_1;
        reg_len   = LenDevStatus;
      end
      CMD_DEVICE_RESET: begin
        start_idx = CSR_DEVICE_RESET;
        end_idx   = CSR_DEVICE_RESET;
        reg_len   = LenDevReset;
      end
      CMD_RECOVERY_CTRL: begin
        start_idx = CSR_RECOVERY_CTRL;
        end_idx   = CSR_RECOVERY_CTRL;
        reg_len   = LenRecCtrl;
      end
      CMD_INDIRECT_FIFO_CTRL: begin
        start_idx = CSR_FIFO_CTRL;
        end_idx   = CSR_FIFO_CTRL;
        reg_len   = LenFifoCtrl;
      end
      CMD_INDIRECT_FIFO_STATUS: begin
        start_idx = CSR_FIFO_STATUS_0;
        end_idx   = CSR_FIFO_STATUS_2;
        reg_len   = LenFifoStatus;
      end
      default: ;
    endcase
  end

  always_comb begin
    state_d = st;
    case (st)
      Idle: begin
        if (accept) begin
          if (illegal) state_d = Error;
          else if (cmd_is_rd_i) state_d = CsrRead;
          else if (cmd_code_i == CMD_INDIRECT_FIFO_DATA) state_d = FifoWrite;
          else state_d = CsrWrite;
        end
      end
      CsrWrite, FifoWrite: if (rx_rack_i && last_i) state_d = Done;
      CsrRead: if (res_ready_i) state_d = CsrReadLen;
      CsrReadLen: state_d = CsrReadData;
      CsrReadData: if (rd_xfer && last_i) state_d = Done;
      Error: state_d = Done;
      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= Idle;
      req_pend_q <= 1'b0;
      load_q     <= 1'b0;
      csr_q      <= CSR_INVALID;
      end_q      <= CSR_INVALID;
      len_q      <= '0;
    end else begin
      state_q    <= recovery_enable_i ? state_d : Idle;
      // One request outstanding until its acknowledge
      req_pend_q <= recovery_enable_i && (rx_rreq_o || (req_pend_q && !rx_rack_i));
      load_q     <= accept && !illegal && !cmd_is_rd_i;
      if (accept) begin
        csr_q <= start_idx;
        end_q <= end_idx;
        len_q <= cmd_is_rd_i ? reg_len : cmd_len_i;
      end else if ((wr_en_o || (rd_xfer && (byte_idx_i == 2'd3))) && (csr_q < end_q)) begin
        // Extra words rewrite or reread the last register word
        csr_q <= csr_e'(csr_q + 4'd1);
      end
    end
  end

  assign cmd_done_o     = (st == Done);
  assign status_upd_o   = (st == Done);
  assign rx_queue_clr_o = (st == Error);
  assign rx_rreq_o      = !req_pend_q &&
                          ((st == CsrWrite) || ((st == FifoWrite) && !fifo_full_i));
  assign res_valid_o    = (st == CsrReadLen);
  assign res_len_o      = len_q;
  assign res_dvalid_o   = (st == CsrReadData);
  assign res_dlast_o    = res_dvalid_o && last_i;
  assign load_words_o   = load_q;
  assign load_bytes_o   = (st == CsrReadLen);
  assign dec_o          = (((st == CsrWrite) || (st == FifoWrite)) && rx_rack_i) || rd_xfer;
  assign byte_adv_o     = rd_xfer;
  assign csr_idx_o      = csr_q;
  assign wr_en_o        = (st == CsrWrite) && rx_rack_i;
  assign fifo_push_o    = (st == FifoWrite) && rx_rack_i;

endmodule

`default_nettype wire

// File: hdl/recovery_pkg.sv
// Recovery executor definitions
`default_nettype none

package recovery_pkg;

  localparam int DataWidth         = 32;
  localparam int CmdLenWidth       = 16;
  localparam int IndirectFifoDepth = 16;
  localparam int FifoIdxWidth      = $clog2(IndirectFifoDepth);

  // Recovery command codes
  typedef enum logic [7:0] {
    CMD_PROT_CAP             = 8'd34,
    CMD_DEVICE_STATUS        = 8'd36,
    CMD_DEVICE_RESET         = 8'd37,
    CMD_RECOVERY_CTRL        = 8'd38,
    CMD_INDIRECT_FIFO_CTRL   = 8'd45,
    CMD_INDIRECT_FIFO_STATUS = 8'd46,
    CMD_INDIRECT_FIFO_DATA   = 8'd47
  } cmd_e;

  localparam logic [7:0] CmdLowest     = 8'd34;
  localparam logic [7:0] CmdHighest    = 8'd47;
  // Codes above this one need recovery mode
  localparam logic [7:0] CmdLastCommon = 8'd39;

  // Register word index
  typedef enum logic [3:0] {
    CSR_PROT_CAP_0      = 4'd0,
    CSR_PROT_CAP_1      = 4'd1,
    CSR_PROT_CAP_2      = 4'd2,
    CSR_PROT_CAP_3      = 4'd3,
    CSR_DEVICE_STATUS_0 = 4'd4,
    CSR_DEVICE_STATUS_1 = 4'd5,
    CSR_DEVICE_RESET    = 4'd6,
    CSR_RECOVERY_CTRL   = 4'd7,
    CSR_FIFO_CTRL       = 4'd8,
    CSR_FIFO_STATUS_0   = 4'd9,
    CSR_FIFO_STATUS_1   = 4'd10,
    CSR_FIFO_STATUS_2   = 4'd11,
    CSR_INVALID         = 4'd15
  } csr_e;

  typedef enum logic [7:0] {
    PROT_OK  = 8'h00,
    PROT_CRC = 8'h04
  } prot_err_e;

  // Register lengths in bytes
  localparam logic [CmdLenWidth-1:0] LenProtCap    = 16'd15;
  localparam logic [CmdLenWidth-1:0] LenDevStatus  = 16'd7;
  localparam logic [CmdLenWidth-1:0] LenDevReset   = 16'd3;
  localparam logic [CmdLenWidth-1:0] LenRecCtrl    = 16'd3;
  localparam logic [CmdLenWidth-1:0] LenFifoCtrl   = 16'd2;
  localparam logic [CmdLenWidth-1:0] LenFifoStatus = 16'd12;

  // Magic string "OCP RECV", version 1.1, agent caps, one CMS region
  localparam logic [DataWidth-1:0] ProtCapWord0 = 32'h2050_434F;
  localparam logic [DataWidth-1:0] ProtCapWord1 = 32'h5643_4552;
  localparam logic [DataWidth-1:0] ProtCapWord2 = 32'h0031_0101;
  localparam logic [DataWidth-1:0] ProtCapWord3 = 32'h0000_0A01;

  localparam logic [7:0] ImageActivateKey = 8'h0F;

  // One queue word, seen as bytes or as register fields
  typedef union packed {
    logic [3:0][7:0] bytes;
    struct packed {
      logic [7:0] rsvd;
      logic [7:0] if_ctrl;
      logic [7:0] forced_recovery;
      logic [7:0] reset_ctrl;
    } dev_reset;
    struct packed {
      logic [7:0] rsvd;
      logic [7:0] activate;
      logic [7:0] rec_img_sel;
      logic [7:0] cms;
    } rec_ctrl;
    struct packed {
      logic [15:0] rsvd;
      logic [7:0]  reset;
      logic [7:0]  cms;
    } fifo_ctrl;
  } csr_word_u;

endpackage

`default_nettype wire

// File: hdl/recovery_regs.sv
// Recovery registers and read mux
`default_nettype none

module recovery_regs (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  recovery_pkg::csr_e                    csr_idx_i,
  input  logic [1:0]                            byte_idx_i,
  input  logic                                  wr_en_i,
  input  logic [recovery_pkg::DataWidth-1:0]    wr_data_i,
  input  logic                                  status_upd_i,
  input  logic                                  cmd_error_i,
  input  logic                                  fifo_full_i,
  input  logic                                  fifo_empty_i,
  input  logic [recovery_pkg::FifoIdxWidth-1:0] wr_idx_i,
  input  logic [recovery_pkg::FifoIdxWidth-1:0] rd_idx_i,
  output logic [7:0]                            rd_byte_o,
  output logic                                  fifo_clr_o,
  output logic                                  image_activated_o
);
  import recovery_pkg::*;

  csr_word_u  wr_word;
  csr_word_u  rd_word;
  prot_err_e  prot_err_q;
  logic [7:0] reset_ctrl_q;
  logic [7:0] forced_rec_q;
  logic [7:0] if_ctrl_q;
  logic [7:0] rec_cms_q;
  logic [7:0] rec_img_sel_q;
  logic [7:0] activate_q;
  logic [7:0] fifo_cms_q;
  logic       fifo_clr_q;

  assign wr_word = wr_data_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      reset_ctrl_q  <= '0;
      forced_rec_q  <= '0;
      if_ctrl_q     <= '0;
      rec_cms_q     <= '0;
      rec_img_sel_q <= '0;
      activate_q    <= '0;
      fifo_cms_q    <= '0;
      fifo_clr_q    <= 1'b0;
      prot_err_q    <= PROT_OK;
    end else begin
      fifo_clr_q <= 1'b0;
      if (wr_en_i) begin
        case (csr_idx_i)
          CSR_DEVICE_RESET: begin
            reset_ctrl_q <= wr_word.dev_reset.reset_ctrl;
            forced_rec_q <= wr_word.dev_reset.forced_recovery;
            if_ctrl_q    <= wr_word.dev_reset.if_ctrl;
          end
          CSR_RECOVERY_CTRL: begin
            rec_cms_q     <= wr_word.rec_ctrl.cms;
            rec_img_sel_q <= wr_word.rec_ctrl.rec_img_sel;
            activate_q    <= wr_word.rec_ctrl.activate;
          end
          CSR_FIFO_CTRL: begin
            fifo_cms_q <= wr_word.fifo_ctrl.cms;
            // Reset byte only pulses the clear
            fifo_clr_q <= (wr_word.fifo_ctrl.reset == 8'd1);
          end
          default: ;
        endcase
      end
      if (status_upd_i) prot_err_q <= cmd_error_i ? PROT_CRC : PROT_OK;
    end
  end

  always_comb begin
    rd_word = '0;
    case (csr_idx_i)
      CSR_PROT_CAP_0: rd_word = ProtCapWord0;
      CSR_PROT_CAP_1: rd_word = ProtCapWord1;
      CSR_PROT_CAP_2: rd_word = ProtCapWord2;
      CSR_PROT_CAP_3: rd_word = ProtCapWord3;
      CSR_DEVICE_STATUS_0: rd_word.bytes[1] = prot_err_q;
      CSR_DEVICE_RESET: begin
        rd_word.dev_reset.reset_ctrl      = reset_ctrl_q;
        rd_word.dev_reset.forced_recovery = forced_rec_q;
        rd_word.dev_reset.if_ctrl         = if_ctrl_q;
      end
      CSR_RECOVERY_CTRL: begin
        rd_word.rec_ctrl.cms         = rec_cms_q;
        rd_word.rec_ctrl.rec_img_sel = rec_img_sel_q;
        rd_word.rec_ctrl.activate    = activate_q;
      end
      CSR_FIFO_CTRL: rd_word.fifo_ctrl.cms = fifo_cms_q;
      CSR_FIFO_STATUS_0: rd_word.bytes[0] = {6'd0, fifo_full_i, fifo_empty_i};
      CSR_FIFO_STATUS_1: rd_word = DataWidth'(wr_idx_i);
      CSR_FIFO_STATUS_2: rd_word = DataWidth'(rd_idx_i);
      default: rd_word = '0;
    endcase
  end

  // Little-endian byte select
  assign rd_byte_o         = rd_word.bytes[byte_idx_i];
  assign fifo_clr_o        = fifo_clr_q;
  assign image_activated_o = (activate_q == ImageActivateKey);

endmodule

`default_nettype wire

// File: hdl/xfer_counter.sv
// Remaining transfer counter
`default_nettype none

module xfer_counter (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic [recovery_pkg::CmdLenWidth-1:0] len_i,
  input  logic                                 load_words_i,
  input  logic                                 load_bytes_i,
  input  logic                                 dec_i,
  input  logic                                 byte_adv_i,
  output logic                                 last_o,
  output logic [1:0]                           byte_idx_o
);
  import recovery_pkg::*;

  logic [CmdLenWidth-1:0] cnt_q;
  logic [CmdLenWidth-1:0] words;
  logic [1:0]             byte_q;

  // Byte length rounded up to whole words
  assign words = {2'b00, len_i[CmdLenWidth-1:2]} + CmdLenWidth'(|len_i[1:0]);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q  <= '0;
      byte_q <= '0;
    end else begin
      if (load_words_i) cnt_q <= words;
      else if (load_bytes_i) cnt_q <= len_i;
      else if (dec_i) cnt_q <= cnt_q - CmdLenWidth'(1);

      // Wraps every four bytes
      if (load_words_i || load_bytes_i) byte_q <= '0;
      else if (byte_adv_i) byte_q <= byte_q + 2'd1;
    end
  end

  assign last_o     = (cnt_q == CmdLenWidth'(1));
  assign byte_idx_o = byte_q;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the recovery executor testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module tb_recovery_executor -f sources.f -o sim_tb \
  && ./obj_dir/sim_tb \
  || { echo "Simulation run returned an error"; exit 1; }

// File: sources.f
hdl/recovery_pkg.sv
hdl/xfer_counter.sv
hdl/recovery_fsm.sv
hdl/recovery_regs.sv
hdl/indirect_fifo.sv
hdl/recovery_executor.sv
testbench/tb_recovery_executor.sv

// File: testbench/recovery_stimulus.txt
# WR code len data-words | RD code len expected-words | ERR code mode error
# POP expected-word | CHK payload_available image_activated | OFF drops recovery enable
RD 34 15 2050434F 56434552 00310101 00000A01
RD 36 7 00000000 00000000
WR 37 3 77A5C31E
RD 37 3 00A5C31E
WR 38 8 00020103 00000500
RD 38 3 00000500
WR 45 2 00000007
RD 45 2 00000007
ERR 60 1 0
ERR 20 1 0
ERR 45 0 0
RD 36 7 00000000 00000000
ERR 37 1 1
RD 36 7 00000400 00000000
RD 36 7 00000000 00000000
WR 47 12 11111111 22222222 33333333
RD 46 12 00000000 00000003 00000000
POP 11111111
POP 22222222
RD 46 12 00000000 00000003 00000002
POP 33333333
RD 46 12 00000001 00000003 00000003
CHK 0 0
WR 47 12 A0000000 A0000001 A0000002
WR 47 12 A0000003 A0000004 A0000005
WR 47 12 A0000006 A0000007 A0000008
WR 47 12 A0000009 A000000A A000000B
WR 47 12 A000000C A000000D A000000E
WR 47 4 A000000F
CHK 1 0
RD 46 12 00000002 00000003 00000003
POP A0000000
POP A0000001
POP A0000002
POP A0000003
POP A0000004
POP A0000005
POP A0000006
POP A0000007
POP A0000008
POP A0000009
POP A000000A
POP A000000B
POP A000000C
POP A000000D
POP A000000E
POP A000000F
CHK 0 0
RD 46 12 00000001 00000003 00000003
WR 47 4 CAFEF00D
CHK 0 0
WR 38 3 000F0500
CHK 1 1
RD 38 3 000F0500
RD 46 12 00000000 00000004 00000003
WR 45 2 00000107
CHK 0 1
RD 46 12 00000001 00000000 00000000
RD 45 2 00000007
WR 47 8 12345678 9ABCDEF0
CHK 1 1
POP 12345678
OFF
CHK 0 1
RD 46 12 00000001 00000000 00000000
RD 37 3 00A5C31E
RD 38 3 000F0500
RD 45 2 00000007

// File: testbench/tb_recovery_executor.sv
// Recovery executor testbench
`default_nettype none

module tb_recovery_executor;
  timeunit 1ns;
  timeprecision 1ps;
  import recovery_pkg::*;

  localparam int MaxCycles = 20000;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   cmd_valid_i;
  logic                   cmd_is_rd_i;
  logic [7:0]             cmd_code_i;
  logic [CmdLenWidth-1:0] cmd_len_i;
  logic                   cmd_error_i;
  logic                   cmd_done_o;
  logic                   rx_rreq_o;
  logic                   rx_rack_i;
  logic [DataWidth-1:0]   rx_rdata_i;
  logic                   res_valid_o;
  logic                   res_ready_i;
  logic [CmdLenWidth-1:0] res_len_o;
  logic                   res_dvalid_o;
  logic                   res_dready_i;
  logic [7:0]             res_data_o;
  logic                   res_dlast_o;
  logic                   fifo_pop_i;
  logic [DataWidth-1:0]   fifo_rdata_o;
  logic                   fifo_empty_o;
  logic                   recovery_enable_i;
  logic                   recovery_mode_i;
  logic                   rx_queue_clr_o;
  logic                   image_activated_o;
  logic                   payload_available_o;

  // Written data or expected read data of the current operation
  logic [DataWidth-1:0] op_words [4];
  logic [DataWidth-1:0] word;
  logic [8*8-1:0]       op;
  logic [8*128-1:0]     line;
  logic                 at_end;
  int                   rx_ptr;
  int                   rx_cnt;
  int                   seed;
  int                   rx_rnd;
  int                   rdy_rnd;
  int                   cycles;
  int                   fd;
  int                   r;
  int                   code;
  int                   len;
  int                   mode;
  int                   err;
  int                   pa;
  int                   ia;
  int                   i;

  recovery_executor DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic report_mismatch(input string what);
    $display("FAIL at %0t ns: %s", $time, what);
    $display("Something failed");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1, "Run aborted");
  endtask

  // One-cycle command pulse that returns in the first cycle after acceptance
  task automatic send_cmd(input int code_v, input logic rd, input int len_v,
                          input logic mode_v, input logic err_v);
    @(posedge clk_i);
    #1;
    cmd_valid_i     = 1'b1;
    cmd_is_rd_i     = rd;
    cmd_code_i      = 8'(code_v);
    cmd_len_i       = CmdLenWidth'(len_v);
    recovery_mode_i = mode_v;
    cmd_error_i     = err_v;
    @(posedge clk_i);
    #1;
    cmd_valid_i = 1'b0;
  endtask

  task automatic run_write(input int code_v, input int len_v);
    logic prev_rack;
    logic done_seen;
    prev_rack = 1'b0;
    done_seen = 1'b0;
    rx_ptr    = 0;
    rx_cnt    = (len_v + 3) / 4;
    send_cmd(code_v, 1'b0, len_v, 1'b1, 1'b0);
    @(negedge clk_i);
    assert (rx_rreq_o) else report_mismatch("no receive request after a write command");
    while (!done_seen) begin
      @(negedge clk_i);
      if (cmd_done_o) begin
        assert (prev_rack) else report_mismatch("cmd_done_o not right after the last acknowledge");
        assert (rx_ptr == rx_cnt)
          else report_mismatch($sformatf("write done after %0d of %0d words", rx_ptr, rx_cnt));
        done_seen = 1'b1;
      end
      prev_rack = rx_rack_i;
    end
    rx_cnt = 0;
  endtask

  task automatic run_read(input int code_v, input int len_v);
    int         k;
    logic       got_len;
    logic       moved;
    logic       done_seen;
    logic       rdy_prev;
    logic [7:0] exp_byte;
    k         = 0;
    got_len   = 1'b0;
    moved     = 1'b0;
    done_seen = 1'b0;
    rdy_prev  = 1'b0;
    send_cmd(code_v, 1'b1, len_v, 1'b1, 1'b0);
    while (!done_seen) begin
      @(negedge clk_i);
      if (cmd_done_o) begin
        assert (moved && k == len_v)
          else report_mismatch($sformatf("read done after %0d of %0d bytes", k, len_v));
        done_seen = 1'b1;
      end else begin
        // Length phase one cycle after res_ready_i is seen
        assert (res_valid_o == (!got_len && rdy_prev))
          else report_mismatch($sformatf("res_valid_o is %b, expected %b",
                                         res_valid_o, !got_len && rdy_prev));
        if (res_valid_o) begin
          assert (!res_dvalid_o && res_len_o == CmdLenWidth'(len_v))
            else report_mismatch($sformatf("length %0d, expected %0d", res_len_o, len_v));
          got_len = 1'b1;
        end else begin
          assert (res_dvalid_o == (got_len && k < len_v))
            else report_mismatch($sformatf("res_dvalid_o is %b at byte %0d", res_dvalid_o, k));
        end
        rdy_prev = res_ready_i;
        moved    = 1'b0;
        if (res_dvalid_o) begin
          // Little-endian bytes of the expected words
          exp_byte = 8'(op_words[k / 4] >> (8 * (k % 4)));
          assert (res_data_o == exp_byte && res_dlast_o == (k == len_v - 1))
            else report_mismatch($sformatf("byte %0d is %h last %b, expected %h",
                                           k, res_data_o, res_dlast_o, exp_byte));
          moved = res_dready_i;
          if (moved) k++;
        end
        @(posedge clk_i);
        #1;
        rdy_rnd      = $random(seed);
        res_dready_i = rdy_rnd[0];
        res_ready_i  = rdy_rnd[1];
      end
    end
  endtask

  // Error cycle first and done in the second cycle after acceptance
  task automatic run_illegal(input int code_v, input int mode_v, input int err_v);
    send_cmd(code_v, 1'b0, 4, mode_v[0], err_v[0]);
    @(negedge clk_i);
    assert (rx_queue_clr_o && !cmd_done_o && !rx_rreq_o)
      else report_mismatch($sformatf("code %0d did not enter the error state", code_v));
    @(negedge clk_i);
    assert (cmd_done_o && !rx_queue_clr_o && !rx_rreq_o)
      else report_mismatch($sformatf("code %0d gave no cmd_done_o two cycles later", code_v));
    @(posedge clk_i);
    #1;
    cmd_error_i     = 1'b0;
    recovery_mode_i = 1'b1;
  endtask

  task automatic check_flags(input int pa_v, input int ia_v);
    @(posedge clk_i);
    #1;
    @(negedge clk_i);
    assert (payload_available_o == pa_v[0] && image_activated_o == ia_v[0])
      else report_mismatch($sformatf("payload %b image %b, expected %0d %0d",
                                     payload_available_o, image_activated_o, pa_v, ia_v));
  endtask

  task automatic pop_word(input logic [DataWidth-1:0] exp_word);
    @(negedge clk_i);
    assert (!fifo_empty_o && fifo_rdata_o == exp_word)
      else report_mismatch($sformatf("FIFO head %h empty %b, expected %h",
                                     fifo_rdata_o, fifo_empty_o, exp_word));
    @(posedge clk_i);
    #1;
    fifo_pop_i = 1'b1;
    @(posedge clk_i);
    #1;
    fifo_pop_i = 1'b0;
  endtask

  task automatic disable_window();
    @(posedge clk_i);
    #1;
    recovery_enable_i = 1'b0;
    @(posedge clk_i);
    repeat (3) begin
      @(negedge clk_i);
      assert (fifo_empty_o && !payload_available_o && !cmd_done_o && !rx_rreq_o &&
              !res_valid_o && !res_dvalid_o && !rx_queue_clr_o)
        else report_mismatch("outputs not idle while recovery is disabled");
    end
    @(posedge clk_i);
    #1;
    recovery_enable_i = 1'b1;
  endtask

  // Receive queue answers each request after 0 to 3 cycles
  initial begin
    forever begin
      @(negedge clk_i);
      if (rx_rreq_o) begin
        assert (rx_ptr < rx_cnt) else report_mismatch("receive request with no word left");
        rx_rnd = $random(seed);
        repeat (rx_rnd[1:0]) @(posedge clk_i);
        @(posedge clk_i);
        #1;
        rx_rack_i  = 1'b1;
        rx_rdata_i = op_words[rx_ptr];
        rx_ptr++;
        @(posedge clk_i);
        #1;
        rx_rack_i = 1'b0;
      end
    end
  end

  initial begin
    cycles = 0;
    forever begin
      @(posedge clk_i);
      cycles++;
      if (cycles >= MaxCycles) abort_run("Timeout: the run did not finish in time");
    end
  end

  initial begin
    seed              = 3;
    rst_ni            = 1'b0;
    cmd_valid_i       = 1'b0;
    cmd_is_rd_i       = 1'b0;
    cmd_code_i        = '0;
    cmd_len_i         = '0;
    cmd_error_i       = 1'b0;
    rx_rack_i         = 1'b0;
    rx_rdata_i        = '0;
    res_ready_i       = 1'b1;
    res_dready_i      = 1'b1;
    fifo_pop_i        = 1'b0;
    recovery_enable_i = 1'b1;
    recovery_mode_i   = 1'b1;
    rx_ptr            = 0;
    rx_cnt            = 0;
    at_end            = 1'b0;
    fd = $fopen("testbench/recovery_stimulus.txt", "r");
    if (fd == 0) abort_run("Cannot open testbench/recovery_stimulus.txt");
    repeat (10) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    while (!at_end) begin
      r = $fscanf(fd, "%s", op);
      if (r != 1) begin
        at_end = 1'b1;
      end else if (op == "#") begin
        r = $fgets(line, fd);
      end else if (op == "WR" || op == "RD") begin
        r = $fscanf(fd, "%d %d", code, len);
        for (i = 0; i < (len + 3) / 4; i++) r = $fscanf(fd, "%h", op_words[i]);
        if (op == "WR") run_write(code, len);
        else run_read(code, len);
      end else if (op == "ERR") begin
        r = $fscanf(fd, "%d %d %d", code, mode, err);
        run_illegal(code, mode, err);
      end else if (op == "POP") begin
        r = $fscanf(fd, "%h", word);
        pop_word(word);
      end else if (op == "CHK") begin
        r = $fscanf(fd, "%d %d", pa, ia);
        check_flags(pa, ia);
      end else if (op == "OFF") begin
        disable_window();
      end else begin
        abort_run($sformatf("Unknown operation %0s in the stimulus file", op));
      end
    end
    $fclose(fd);
    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire
